// File: hdl/dmmu_consts.svh
/*
 * Data MMU constants
 * Word, page and set geometry plus the SPR address fields
 * used to reach the DTLB match and translate registers
 */

`ifndef DMMU_CONSTS_SVH
`define DMMU_CONSTS_SVH

// Address and SPR word width
`define DMMU_DATA_WIDTH 32

// 8 KB pages
`define DMMU_PAGE_BITS 13

// 64 sets, one way
`define DMMU_SET_WIDTH 6

// Pass-through width of the virtual address on a miss
`define DMMU_MISS_ADDR_BITS 24

////////////////////////////////////////
// SPR address layout
////////////////////////////////////////
`define DMMU_SPR_ADDR_WIDTH 16
`define DMMU_SPR_GROUP      1
`define DMMU_SPR_GROUP_MSB  15
`define DMMU_SPR_GROUP_LSB  11
// Either of these set means a DTLB register
`define DMMU_SPR_TLB_HI     10
`define DMMU_SPR_TLB_LO     9
// Set for translate and clear for match
`define DMMU_SPR_TRANS_BIT  7

`endif

// File: hdl/dmmu_pkg.sv
/*
 * Data MMU types
 * DTLB match and translate entry layouts, and the word union
 * shared by both register arrays and the SPR write data
 */

`include "dmmu_consts.svh"

package dmmu_pkg;

  // Match register, one per set
  typedef struct packed {
    logic [`DMMU_DATA_WIDTH-`DMMU_PAGE_BITS-1:0] vpn;
    logic [`DMMU_PAGE_BITS-2:0]                  rsvd;
    logic                                        valid;
  } match_entry_t;

  // Translate register, one per set
  typedef struct packed {
    logic [`DMMU_DATA_WIDTH-`DMMU_PAGE_BITS-1:0] ppn;
    logic [`DMMU_PAGE_BITS-11:0]                 rsvd;
    // Supervisor write / read enable
    logic                                        swe;
    logic                                        sre;
    // User write / read enable
    logic                                        uwe;
    logic                                        ure;
    logic                                        dirty;
    logic                                        accessed;
    // Weakly ordered memory
    logic                                        wom;
    // Write-back cache
    logic                                        wbc;
    // Cache inhibit
    logic                                        ci;
    // Cache coherent
    logic                                        cc;
  } trans_entry_t;

  // Same word, two meanings depending on which array it targets
  typedef union packed {
    match_entry_t match;
    trans_entry_t trans;
  } tlb_word_u;

endpackage

// File: hdl/dtlb_ram_if.sv
/*
 * DTLB register array port
 * Set address, write enable, write word and registered read word
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

interface dtlb_ram_if;

  logic [`DMMU_SET_WIDTH-1:0] addr;
  logic                       we;
  dmmu_pkg::tlb_word_u        din;
  dmmu_pkg::tlb_word_u        dout;

  // SPR decoder side
  modport ctrl (output addr, we, din, input dout);

  // Storage side
  modport ram (input addr, we, din, output dout);

  // Lookup only looks at the read word
  modport mon (input dout);

endinterface

// File: hdl/dtlb_entry_ram.sv
/*
 * DTLB register array
 * Single port, synchronous write, registered read.
 * A write and read of the same set returns the old word
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

module dtlb_entry_ram (
  input logic      clk,
  dtlb_ram_if.ram  ram_if
);

  localparam int NUM_SETS = 1 << `DMMU_SET_WIDTH;

  // Entry storage, contents undefined until software fills them
  dmmu_pkg::tlb_word_u mem [NUM_SETS];

  always_ff @(posedge clk) begin
    if (ram_if.we) begin
      mem[ram_if.addr] <= ram_if.din;
    end
    // Read before write
    ram_if.dout <= mem[ram_if.addr];
  end

endmodule

// File: hdl/dmmu_spr_decode.sv
/*
 * Data MMU SPR decode
 * Group and array selects, array address steering, write path,
 * one-cycle acknowledge and read-back selection
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

module dmmu_spr_decode (
  input  logic                            clk,
  input  logic                            rst,

  input  logic [`DMMU_SPR_ADDR_WIDTH-1:0] spr_bus_addr_i,
  input  logic                            spr_bus_we_i,
  input  logic                            spr_bus_stb_i,
  input  dmmu_pkg::tlb_word_u             spr_bus_dat_i,
  input  logic [`DMMU_DATA_WIDTH-1:0]     virt_addr_i,

  output logic [`DMMU_DATA_WIDTH-1:0]     spr_bus_dat_o,
  output logic                            spr_bus_ack_o,

  dtlb_ram_if.ctrl                        match_if,
  dtlb_ram_if.ctrl                        trans_if
);

  localparam int GROUP_WIDTH = `DMMU_SPR_GROUP_MSB - `DMMU_SPR_GROUP_LSB + 1;

  logic                       mmu_cs;
  logic                       tlb_sel;
  logic                       match_cs;
  logic                       trans_cs;
  logic                       mmu_cs_r;
  logic                       match_cs_r;
  logic                       trans_cs_r;
  logic [`DMMU_SET_WIDTH-1:0] spr_set;
  logic [`DMMU_SET_WIDTH-1:0] lookup_set;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Strobe aimed at the MMU group
  assign mmu_cs = spr_bus_stb_i &
    (spr_bus_addr_i[`DMMU_SPR_GROUP_MSB:`DMMU_SPR_GROUP_LSB] ==
     GROUP_WIDTH'(`DMMU_SPR_GROUP));

  // DTLB register space
  assign tlb_sel  = spr_bus_addr_i[`DMMU_SPR_TLB_HI] | spr_bus_addr_i[`DMMU_SPR_TLB_LO];

  assign match_cs = mmu_cs & tlb_sel & ~spr_bus_addr_i[`DMMU_SPR_TRANS_BIT];
  assign trans_cs = mmu_cs & tlb_sel & spr_bus_addr_i[`DMMU_SPR_TRANS_BIT];

  ////////////////////////////////////////
  // Array address and write path
  ////////////////////////////////////////

  assign spr_set    = spr_bus_addr_i[`DMMU_SET_WIDTH-1:0];
  // Set index sits just above the page offset
  assign lookup_set = virt_addr_i[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH];

  // SPR access owns the array while it is selected
  assign match_if.addr = match_cs ? spr_set : lookup_set;
  assign trans_if.addr = trans_cs ? spr_set : lookup_set;

  assign match_if.we   = match_cs & spr_bus_we_i;
  assign trans_if.we   = trans_cs & spr_bus_we_i;

  // Same word into both, only the enabled one takes it
  assign match_if.din  = spr_bus_dat_i;
  assign trans_if.din  = spr_bus_dat_i;

  ////////////////////////////////////////
  // Acknowledge and read-back
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mmu_cs_r   <= 1'b0;
      match_cs_r <= 1'b0;
      trans_cs_r <= 1'b0;
    end else begin
      mmu_cs_r   <= mmu_cs;
      match_cs_r <= match_cs;
      trans_cs_r <= trans_cs;
    end
  end

  // Drops together with the strobe
  assign spr_bus_ack_o = mmu_cs_r & mmu_cs;

  // Array word is ready one cycle after the address, in the ack cycle
  always_comb begin
    if (match_cs_r) begin
      spr_bus_dat_o = match_if.dout;
    end else if (trans_cs_r) begin
      spr_bus_dat_o = trans_if.dout;
    end else begin
      // Other MMU registers read as zero
      spr_bus_dat_o = '0;
    end
  end

endmodule

// File: hdl/dmmu_lookup.sv
/*
 * Data MMU lookup
 * Tag compare against the late virtual address, physical address
 * forming, miss and cache inhibit flags, load/store permission check
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

module dmmu_lookup (
  input  logic [`DMMU_DATA_WIDTH-1:0] virt_addr_match_i,
  input  logic                        op_load_i,
  input  logic                        op_store_i,
  input  logic                        supervisor_mode_i,

  dtlb_ram_if.mon                     match_if,
  dtlb_ram_if.mon                     trans_if,

  output logic [`DMMU_DATA_WIDTH-1:0] phys_addr_o,
  output logic                        tlb_miss_o,
  output logic                        cache_inhibit_o,
  output logic                        pagefault_o
);

  localparam int VPN_WIDTH  = `DMMU_DATA_WIDTH - `DMMU_PAGE_BITS;
  localparam int MISS_ZEROS = `DMMU_DATA_WIDTH - `DMMU_MISS_ADDR_BITS;

  dmmu_pkg::match_entry_t match_e;
  dmmu_pkg::trans_entry_t trans_e;
  logic [VPN_WIDTH-1:0]   vpn;
  logic                   hit;

  // Effective permissions, zero on a miss
  logic                   swe;
  logic                   sre;
  logic                   uwe;
  logic                   ure;

  // Match view of one array, translate view of the other
  assign match_e = match_if.dout.match;
  assign trans_e = trans_if.dout.trans;

  assign vpn = virt_addr_match_i[`DMMU_DATA_WIDTH-1:`DMMU_PAGE_BITS];
  assign hit = match_e.valid & (match_e.vpn == vpn);

  ////////////////////////////////////////
  // Translation
  ////////////////////////////////////////

  always_comb begin
    // Miss defaults, low address bits pass straight through
    tlb_miss_o      = 1'b1;
    phys_addr_o     = {{MISS_ZEROS{1'b0}},
                       virt_addr_match_i[`DMMU_MISS_ADDR_BITS-1:0]};
    cache_inhibit_o = 1'b0;
    swe             = 1'b0;
    sre             = 1'b0;
    uwe             = 1'b0;
    ure             = 1'b0;

    if (hit) begin
      tlb_miss_o      = 1'b0;
      phys_addr_o     = {trans_e.ppn, virt_addr_match_i[`DMMU_PAGE_BITS-1:0]};
      cache_inhibit_o = trans_e.ci;
      swe             = trans_e.swe;
      sre             = trans_e.sre;
      uwe             = trans_e.uwe;
      ure             = trans_e.ure;
    end
  end

  ////////////////////////////////////////
  // Permission check
  ////////////////////////////////////////

  // A miss has no permissions, so any access to it faults
  assign pagefault_o = supervisor_mode_i ?
    (op_store_i & ~swe) | (op_load_i & ~sre) :
    (op_store_i & ~uwe) | (op_load_i & ~ure);

endmodule

// File: hdl/dmmu_top.sv
/*
 * Data MMU top level
 * SPR decoder, DTLB match and translate arrays and the lookup
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

module dmmu_top (
  input  logic                            clk,
  input  logic                            rst,

  // SPR bus
  input  logic [`DMMU_SPR_ADDR_WIDTH-1:0] spr_bus_addr_i,
  input  logic                            spr_bus_we_i,
  input  logic                            spr_bus_stb_i,
  input  logic [`DMMU_DATA_WIDTH-1:0]     spr_bus_dat_i,
  output logic [`DMMU_DATA_WIDTH-1:0]     spr_bus_dat_o,
  output logic                            spr_bus_ack_o,

  // Lookup, early and late address of the same access
  input  logic [`DMMU_DATA_WIDTH-1:0]     virt_addr_i,
  input  logic [`DMMU_DATA_WIDTH-1:0]     virt_addr_match_i,
  input  logic                            op_load_i,
  input  logic                            op_store_i,
  input  logic                            supervisor_mode_i,
  output logic [`DMMU_DATA_WIDTH-1:0]     phys_addr_o,
  output logic                            tlb_miss_o,
  output logic                            cache_inhibit_o,
  output logic                            pagefault_o
);

  dmmu_pkg::tlb_word_u spr_wdata;

  dtlb_ram_if match_if ();
  dtlb_ram_if trans_if ();

  assign spr_wdata = spr_bus_dat_i;

  dmmu_spr_decode u_spr_decode (
    .clk            (clk),
    .rst            (rst),
    .spr_bus_addr_i (spr_bus_addr_i),
    .spr_bus_we_i   (spr_bus_we_i),
    .spr_bus_stb_i  (spr_bus_stb_i),
    .spr_bus_dat_i  (spr_wdata),
    .virt_addr_i    (virt_addr_i),
    .spr_bus_dat_o  (spr_bus_dat_o),
    .spr_bus_ack_o  (spr_bus_ack_o),
    .match_if       (match_if.ctrl),
    .trans_if       (trans_if.ctrl)
  );

  // DTLB match registers
  dtlb_entry_ram u_match_ram (
    .clk    (clk),
    .ram_if (match_if.ram)
  );

  // DTLB translate registers
  dtlb_entry_ram u_trans_ram (
    .clk    (clk),
    .ram_if (trans_if.ram)
  );

  dmmu_lookup u_lookup (
    .virt_addr_match_i (virt_addr_match_i),
    .op_load_i         (op_load_i),
    .op_store_i        (op_store_i),
    .supervisor_mode_i (supervisor_mode_i),
    .match_if          (match_if.mon),
    .trans_if          (trans_if.mon),
    .phys_addr_o       (phys_addr_o),
    .tlb_miss_o        (tlb_miss_o),
    .cache_inhibit_o   (cache_inhibit_o),
    .pagefault_o       (pagefault_o)
  );

endmodule

// File: verification/tb_dmmu.sv
/*
 * Data MMU testbench
 * SPR write and read-back of both DTLB arrays, decode edges,
 * hit and miss translation, load/store permission check
 */

`timescale 1ns/1ns

`include "dmmu_consts.svh"

module tb_dmmu;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_SETS    = 1 << `DMMU_SET_WIDTH;
  localparam int ACK_LIMIT   = 4;
  localparam int ENTRY_TESTS = 48;
  // Every set written twice and read twice, two decode checks, six per entry test
  localparam int TEST_COUNT  = 4 * NUM_SETS + 2 + ENTRY_TESTS * 6;
  localparam int TEST_CYCLES = 8;
  localparam int TIMEOUT_NS  = TEST_COUNT * TEST_CYCLES * CLK_PERIOD;

  // Group 1 with bit 9 set and bit 7 picking translate
  localparam logic [15:0] MATCH_BASE = 16'h0A00;
  localparam logic [15:0] TRANS_BASE = 16'h0A80;
  // MMU group with bits 10 and 9 clear
  localparam logic [15:0] MMU_OTHER  = 16'h0800;
  // Group 2
  localparam logic [15:0] FOREIGN    = 16'h1200;

  logic        clk = 1'b0;
  logic        rst;
  logic [15:0] spr_addr;
  logic        spr_we;
  logic        spr_stb;
  logic [31:0] spr_wdata;
  logic [31:0] spr_rdata;
  logic        spr_ack;
  logic [31:0] virt_addr;
  logic [31:0] virt_addr_match;
  logic        op_load;
  logic        op_store;
  logic        supervisor;
  logic [31:0] phys_addr;
  logic        tlb_miss;
  logic        cache_inhibit;
  logic        pagefault;

  int          errors;
  int          checks;
  // Shadow copies of what software wrote
  logic [31:0] shadow_match [NUM_SETS];
  logic [31:0] shadow_trans [NUM_SETS];

  always #(CLK_PERIOD / 2) clk = ~clk;

  dmmu_top UUT (
    .clk               (clk),
    .rst               (rst),
    .spr_bus_addr_i    (spr_addr),
    .spr_bus_we_i      (spr_we),
    .spr_bus_stb_i     (spr_stb),
    .spr_bus_dat_i     (spr_wdata),
    .spr_bus_dat_o     (spr_rdata),
    .spr_bus_ack_o     (spr_ack),
    .virt_addr_i       (virt_addr),
    .virt_addr_match_i (virt_addr_match),
    .op_load_i         (op_load),
    .op_store_i        (op_store),
    .supervisor_mode_i (supervisor),
    .phys_addr_o       (phys_addr),
    .tlb_miss_o        (tlb_miss),
    .cache_inhibit_o   (cache_inhibit),
    .pagefault_o       (pagefault)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Strobe held until ack with outputs sampled on the falling edge
  task automatic spr_access(input logic [15:0] addr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    spr_addr  = addr;
    spr_we    = we;
    spr_wdata = wdata;
    spr_stb   = 1'b1;
    // No ack before the first clock edge of the strobe
    #(CLK_PERIOD / 4);
    checks++;
    assert (!spr_ack) else begin
      errors++;
      $display("SPR access to %h acknowledged in the first strobe cycle", addr);
    end
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!spr_ack && wait_cycles < ACK_LIMIT);
    checks++;
    assert (spr_ack) else begin
      errors++;
      $display("SPR access to %h was never acknowledged", addr);
    end
    assert (!spr_ack || wait_cycles == 1) else begin
      errors++;
      $display("SPR access to %h acknowledged %0d cycles after the strobe", addr, wait_cycles);
    end
    rdata   = spr_rdata;
    spr_stb = 1'b0;
    spr_we  = 1'b0;
  endtask

  task automatic write_entry(input logic trans, input logic [5:0] set, input logic [31:0] word);
    logic [31:0] rdata;
    spr_access((trans ? TRANS_BASE : MATCH_BASE) | {10'b0, set}, 1'b1, word, rdata);
    if (trans) begin
      shadow_trans[set] = word;
    end else begin
      shadow_match[set] = word;
    end
  endtask

  task automatic read_entry(input logic trans, input logic [5:0] set);
    logic [31:0] rdata;
    spr_access((trans ? TRANS_BASE : MATCH_BASE) | {10'b0, set}, 1'b0, '0, rdata);
    check_word("spr_bus_dat_o", rdata, trans ? shadow_trans[set] : shadow_match[set]);
  endtask

  task automatic check_decode_edges();
    logic [31:0] r;
    logic [31:0] rdata;
    r = $urandom;
    // Foreign group with the strobe held past the ack window
    @(negedge clk);
    spr_addr = FOREIGN | {10'b0, r[5:0]};
    spr_stb  = 1'b1;
    checks++;
    repeat (ACK_LIMIT) begin
      @(negedge clk);
      assert (!spr_ack) else begin
        errors++;
        $display("Strobe outside the MMU group was acknowledged");
      end
    end
    spr_stb = 1'b0;
    // Non-DTLB MMU register reads zero
    spr_access(MMU_OTHER | {7'b0, r[14:6]}, 1'b0, '0, rdata);
    check_word("spr_bus_dat_o", rdata, 32'h0);
  endtask

  // Expected result worked out from the shadow entries
  task automatic lookup(input logic [31:0] va, input logic sup, input logic ld, input logic st);
    logic [31:0] m;
    logic [31:0] t;
    logic        hit;
    logic [3:0]  perm;
    logic [31:0] exp_phys;
    logic        exp_fault;
    m        = shadow_match[va[18:13]];
    t        = shadow_trans[va[18:13]];
    hit      = m[0] && (m[31:13] == va[31:13]);
    // swe, sre, uwe, ure
    perm     = hit ? t[9:6] : 4'b0;
    exp_phys = hit ? {t[31:13], va[12:0]} : {8'h0, va[23:0]};
    exp_fault = sup ? ((st && !perm[3]) || (ld && !perm[2])) :
                      ((st && !perm[1]) || (ld && !perm[0]));
    @(negedge clk);
    virt_addr = va;
    @(negedge clk);
    virt_addr_match = va;
    op_load         = ld;
    op_store        = st;
    supervisor      = sup;
    // Early address moves on, so only a one-cycle read gives the right words
    virt_addr       = ~va;
    #(CLK_PERIOD / 4);
    check_word("tlb_miss_o", 32'(tlb_miss), 32'(!hit));
    check_word("phys_addr_o", phys_addr, exp_phys);
    check_word("cache_inhibit_o", 32'(cache_inhibit), 32'(hit && t[1]));
    check_word("pagefault_o", 32'(pagefault), 32'(exp_fault));
    @(negedge clk);
    op_load  = 1'b0;
    op_store = 1'b0;
  endtask

  // Kind 0 hit, 1 invalid entry, 2 VPN mismatch
  task automatic entry_test(input int kind);
    logic [31:0] va;
    logic [31:0] r;
    logic        valid;
    va    = $urandom;
    r     = $urandom;
    valid = (kind != 1);
    write_entry(1'b0, va[18:13], {va[31:13], r[11:0], valid});
    write_entry(1'b1, va[18:13], $urandom);
    if (kind == 2) begin
      va[31] = ~va[31];
    end
    // Both modes with load then store
    for (int i = 0; i < 4; i++) begin
      lookup(va, i[1], i[0], !i[0]);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(90368));
    errors          = 0;
    checks          = 0;
    rst             = 1'b1;
    // Strobe held through reset so a stale registered select shows as an ack
    spr_addr        = MMU_OTHER;
    spr_we          = 1'b0;
    spr_stb         = 1'b1;
    spr_wdata       = '0;
    virt_addr       = '0;
    virt_addr_match = '0;
    op_load         = 1'b0;
    op_store        = 1'b0;
    supervisor      = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_word("spr_bus_ack_o", 32'(spr_ack), 32'h0);
    spr_stb = 1'b0;

    // Fill every set, then read back in random order
    for (int s = 0; s < NUM_SETS; s++) begin
      write_entry(1'b0, 6'(s), $urandom);
      write_entry(1'b1, 6'(s), $urandom);
    end
    for (int n = 0; n < 2 * NUM_SETS; n++) begin
      logic [31:0] r;
      r = $urandom;
      read_entry(r[6], r[5:0]);
    end

    check_decode_edges();

    for (int n = 0; n < ENTRY_TESTS; n++) begin
      entry_test(n % 3);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, test sequence did not finish", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/dmmu_pkg.sv
hdl/dtlb_ram_if.sv
hdl/dtlb_entry_ram.sv
hdl/dmmu_spr_decode.sv
hdl/dmmu_lookup.sv
hdl/dmmu_top.sv
verification/tb_dmmu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dmmu
FILELIST  = sim.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
